// ==== hw/mosaic_geom_pkg.sv ====
package mosaic_geom_pkg;

   // Block grid and block size in pixels.
   localparam int HBLKS = 4;
   localparam int VBLKS = 3;
   localparam int BLK_W = 4;
   localparam int BLK_H = 4;

   localparam int FRAME_W    = HBLKS * BLK_W;
   localparam int FRAME_H    = VBLKS * BLK_H;
   localparam int PX_PER_BLK = BLK_W * BLK_H;

   // Index widths for block coordinates and the position inside a block.
   localparam int HT_W = (HBLKS > 1) ? $clog2(HBLKS) : 1;
   localparam int VT_W = (VBLKS > 1) ? $clog2(VBLKS) : 1;
   localparam int BX_W = (BLK_W > 1) ? $clog2(BLK_W) : 1;
   localparam int BY_W = (BLK_H > 1) ? $clog2(BLK_H) : 1;

   localparam logic [HT_W-1:0] HT_LAST = HT_W'(HBLKS - 1);
   localparam logic [VT_W-1:0] VT_LAST = VT_W'(VBLKS - 1);
   localparam logic [BX_W-1:0] BX_LAST = BX_W'(BLK_W - 1);
   localparam logic [BY_W-1:0] BY_LAST = BY_W'(BLK_H - 1);

   localparam int ACC_W = $clog2(PX_PER_BLK * 255 * 512 + 1); // Full-scale block sum fits.

   // Luma weights scaled so that they sum to 512.
   localparam logic [ACC_W-1:0] W_R = ACC_W'(109);
   localparam logic [ACC_W-1:0] W_G = ACC_W'(366);
   localparam logic [ACC_W-1:0] W_B = ACC_W'(37);

   localparam logic [ACC_W-1:0] LUMA_THRES = ACC_W'(PX_PER_BLK * 128 * 512); // Mean luma 128.

endpackage

// ==== hw/mosaic_bus_pkg.sv ====
package mosaic_bus_pkg;

   localparam int WB_ADR_W = 8;
   localparam int WB_DAT_W = 8; // Must hold one bitmap row.

   // Bitmap row r is mapped at word address ROW_BASE + r.
   localparam logic [WB_ADR_W-1:0] ROW_BASE = WB_ADR_W'('h10);
   localparam logic [WB_ADR_W-1:0] ROW_CNT  = WB_ADR_W'(mosaic_geom_pkg::VBLKS);

endpackage

// ==== hw/blk_timing.sv ====
`timescale 1ns/10ps

module blk_timing (
   input  logic                             clk_i,
   input  logic                             rst_n_i,
   input  logic                             vs_i,
   input  logic                             de_i,
   input  logic [23:0]                      wd_i,
   output logic [mosaic_geom_pkg::HT_W-1:0] ht_o,
   output logic [mosaic_geom_pkg::VT_W-1:0] vt_o,
   output logic                             px_valid_o,
   output logic [23:0]                      px_o,
   output logic                             row_end_o,
   output logic                             frame_start_o
);

   logic [mosaic_geom_pkg::BX_W-1:0] bx_q;   // Pixel position inside the current block.
   logic [mosaic_geom_pkg::HT_W-1:0] hcol_q; // Block column of the next pixel.
   logic [mosaic_geom_pkg::BY_W-1:0] by_q;   // Line position inside the current block row.
   logic [mosaic_geom_pkg::VT_W-1:0] vrow_q; // Block row of the current line.
   logic                             de_fall;

   assign de_fall = px_valid_o & ~de_i; // Last pixel of a line was on the previous cycle.

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         bx_q       <= '0;
         hcol_q     <= '0;
         ht_o       <= '0;
         px_valid_o <= 1'b0;
      end else begin
         px_valid_o <= de_i;
         if (de_i) begin
            ht_o <= hcol_q; // Column tag travels with the registered pixel.
            if (bx_q == mosaic_geom_pkg::BX_LAST) begin
               bx_q <= '0;
               if (hcol_q == mosaic_geom_pkg::HT_LAST) begin
                  hcol_q <= '0;
               end else begin
                  hcol_q <= hcol_q + 1'b1;
               end
            end else begin
               bx_q <= bx_q + 1'b1;
            end
         end else begin
            bx_q   <= '0; // Every line starts at column 0.
            hcol_q <= '0;
         end
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         by_q          <= '0;
         vrow_q        <= '0;
         vt_o          <= '0;
         row_end_o     <= 1'b0;
         frame_start_o <= 1'b0;
      end else begin
         frame_start_o <= vs_i;
         row_end_o     <= 1'b0;
         if (vs_i) begin
            by_q   <= '0;
            vrow_q <= '0;
         end else if (de_fall) begin
            if (by_q == mosaic_geom_pkg::BY_LAST) begin
               by_q      <= '0;
               vt_o      <= vrow_q; // The row that this pulse closes.
               row_end_o <= 1'b1;
               if (vrow_q == mosaic_geom_pkg::VT_LAST) begin
                  vrow_q <= '0;
               end else begin
                  vrow_q <= vrow_q + 1'b1;
               end
            end else begin
               by_q <= by_q + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      px_o <= wd_i;
   end

endmodule

// ==== hw/luma_accum.sv ====
`timescale 1ns/10ps

module luma_accum (
   input  logic                             clk_i,
   input  logic                             rst_n_i,
   input  logic [mosaic_geom_pkg::HT_W-1:0] ht_i,
   input  logic [mosaic_geom_pkg::VT_W-1:0] vt_i,
   input  logic                             px_valid_i,
   input  logic [23:0]                      px_i,
   input  logic                             row_end_i,
   output logic                             bit_we_o,
   output logic [mosaic_geom_pkg::HT_W-1:0] bit_ht_o,
   output logic [mosaic_geom_pkg::VT_W-1:0] bit_vt_o,
   output logic                             bit_o
);

   // One running sum per block column, shared by all lines of a block row.
   logic [mosaic_geom_pkg::ACC_W-1:0] acc_q [mosaic_geom_pkg::HBLKS];
   logic [mosaic_geom_pkg::ACC_W-1:0] luma;

   logic                             scan_act_q; // Columns 1 and up still to be thresholded.
   logic [mosaic_geom_pkg::HT_W-1:0] scan_col_q;
   logic                             sel_go;
   logic [mosaic_geom_pkg::HT_W-1:0] sel_col;

   assign luma = mosaic_geom_pkg::W_R * px_i[23:16]
               + mosaic_geom_pkg::W_G * px_i[15:8]
               + mosaic_geom_pkg::W_B * px_i[7:0];

   // The row-end pulse itself handles column 0, so the scan needs no idle cycle.
   assign sel_go  = row_end_i | scan_act_q;
   assign sel_col = row_end_i ? '0 : scan_col_q;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         acc_q <= '{default: '0};
      end else begin
         if (px_valid_i) begin
            acc_q[ht_i] <= acc_q[ht_i] + luma;
         end
         if (sel_go) begin
            acc_q[sel_col] <= '0; // Cleared as it is thresholded.
         end
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         scan_act_q <= 1'b0;
         scan_col_q <= '0;
      end else if (sel_go) begin
         if (sel_col == mosaic_geom_pkg::HT_LAST) begin
            scan_act_q <= 1'b0;
            scan_col_q <= '0;
         end else begin
            scan_act_q <= 1'b1;
            scan_col_q <= sel_col + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         bit_we_o <= 1'b0;
         bit_ht_o <= '0;
         bit_vt_o <= '0;
         bit_o    <= 1'b0;
      end else begin
         bit_we_o <= sel_go;
         if (row_end_i) begin
            bit_vt_o <= vt_i; // Held for the whole scan.
         end
         if (sel_go) begin
            bit_ht_o <= sel_col;
            bit_o    <= (acc_q[sel_col] >= mosaic_geom_pkg::LUMA_THRES);
         end
      end
   end

endmodule

// ==== hw/blk_bitmap.sv ====
`timescale 1ns/10ps

module blk_bitmap (
   input  logic                                 clk_i,
   input  logic                                 rst_n_i,
   input  logic                                 bit_we_i,
   input  logic [mosaic_geom_pkg::HT_W-1:0]     bit_ht_i,
   input  logic [mosaic_geom_pkg::VT_W-1:0]     bit_vt_i,
   input  logic                                 bit_i,
   input  logic                                 frame_start_i,
   input  logic                                 wb_cyc_i,
   input  logic                                 wb_stb_i,
   input  logic                                 wb_we_i,
   input  logic [mosaic_bus_pkg::WB_ADR_W-1:0]  wb_adr_i,
   output logic [mosaic_bus_pkg::WB_DAT_W-1:0]  wb_dat_o,
   output logic                                 wb_ack_o
);

   logic [mosaic_geom_pkg::HBLKS-1:0] work_q [mosaic_geom_pkg::VBLKS]; // Filled by the scan.
   logic [mosaic_geom_pkg::HBLKS-1:0] disp_q [mosaic_geom_pkg::VBLKS]; // Seen by the bus.

   logic                                req;
   logic                                row_hit;
   logic [mosaic_bus_pkg::WB_ADR_W-1:0] row_off;
   logic [mosaic_bus_pkg::WB_DAT_W-1:0] rd_data;

   assign req     = wb_cyc_i & wb_stb_i;
   assign row_off = wb_adr_i - mosaic_bus_pkg::ROW_BASE; // Wraps high below the base.
   assign row_hit = (row_off < mosaic_bus_pkg::ROW_CNT);

   always_comb begin
      rd_data = '0;
      if (row_hit && !wb_we_i) begin
         rd_data[mosaic_geom_pkg::HBLKS-1:0] = disp_q[row_off[mosaic_geom_pkg::VT_W-1:0]];
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         work_q <= '{default: '0};
         disp_q <= '{default: '0};
      end else begin
         if (bit_we_i) begin
            work_q[bit_vt_i][bit_ht_i] <= bit_i;
         end
         if (frame_start_i) begin
            disp_q <= work_q; // The finished frame becomes visible.
         end
      end
   end

   // One ack per request, then at least one idle cycle.
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wb_ack_o <= 1'b0;
      end else begin
         wb_ack_o <= req & ~wb_ack_o;
      end
   end

   always_ff @(posedge clk_i) begin
      if (req && !wb_ack_o) begin
         wb_dat_o <= rd_data;
      end
   end

endmodule

// ==== hw/mosaic_top.sv ====
`timescale 1ns/10ps

module mosaic_top (
   input  logic                                clk_i,
   input  logic                                rst_n_i,
   input  logic                                vs_i,
   input  logic                                de_i,
   input  logic [23:0]                         wd_i,
   input  logic                                wb_cyc_i,
   input  logic                                wb_stb_i,
   input  logic                                wb_we_i,
   input  logic [mosaic_bus_pkg::WB_ADR_W-1:0] wb_adr_i,
   output logic [mosaic_bus_pkg::WB_DAT_W-1:0] wb_dat_o,
   output logic                                wb_ack_o
);

   logic [mosaic_geom_pkg::HT_W-1:0] ht;
   logic [mosaic_geom_pkg::VT_W-1:0] vt;
   logic                             px_valid;
   logic [23:0]                      px;
   logic                             row_end;
   logic                             frame_start;

   logic                             bit_we;
   logic [mosaic_geom_pkg::HT_W-1:0] bit_ht;
   logic [mosaic_geom_pkg::VT_W-1:0] bit_vt;
   logic                             bit_val;

   blk_timing i_decode (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .vs_i          (vs_i),
      .de_i          (de_i),
      .wd_i          (wd_i),
      .ht_o          (ht),
      .vt_o          (vt),
      .px_valid_o    (px_valid),
      .px_o          (px),
      .row_end_o     (row_end),
      .frame_start_o (frame_start)
   );

   luma_accum i_execute (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .ht_i       (ht),
      .vt_i       (vt),
      .px_valid_i (px_valid),
      .px_i       (px),
      .row_end_i  (row_end),
      .bit_we_o   (bit_we),
      .bit_ht_o   (bit_ht),
      .bit_vt_o   (bit_vt),
      .bit_o      (bit_val)
   );

   blk_bitmap i_result (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .bit_we_i      (bit_we),
      .bit_ht_i      (bit_ht),
      .bit_vt_i      (bit_vt),
      .bit_i         (bit_val),
      .frame_start_i (frame_start),
      .wb_cyc_i      (wb_cyc_i),
      .wb_stb_i      (wb_stb_i),
      .wb_we_i       (wb_we_i),
      .wb_adr_i      (wb_adr_i),
      .wb_dat_o      (wb_dat_o),
      .wb_ack_o      (wb_ack_o)
   );

endmodule

// ==== verification/mosaic_checker.sv ====
`timescale 1ns/10ps

module mosaic_checker (
   input  logic                                clk_i,
   input  logic                                rst_n_i,
   input  logic                                wb_cyc_i,
   input  logic                                wb_stb_i,
   input  logic                                wb_ack_i,
   input  logic [mosaic_bus_pkg::WB_DAT_W-1:0] wb_dat_i,
   input  logic                                cmp_i,
   input  int                                  exp_row_i,
   input  logic [mosaic_bus_pkg::WB_DAT_W-1:0] exp_dat_i,
   input  logic [7:0]                          test_id_i,
   input  logic                                test_end_i,
   input  logic                                all_done_i,
   output int                                  err_cnt_o,
   output int                                  chk_cnt_o
);

   logic wait_q;   // A request was seen and its ack is due on the next edge.
   int   t_chk;
   int   t_err;
   int   n_test;

   always @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wait_q    = 1'b0;
         t_chk     = 0;
         t_err     = 0;
         n_test    = 0;
         err_cnt_o = 0;
         chk_cnt_o = 0;
      end else begin
         if (wb_ack_i) begin
            if (!wait_q) begin
               err_cnt_o++;
               t_err++;
               $display("unexpected ack with no pending request at %0t", $time);
            end else if (cmp_i) begin
               chk_cnt_o++;
               t_chk++;
               if (wb_dat_i !== exp_dat_i) begin
                  err_cnt_o++;
                  t_err++;
                  $display("mismatch wb_dat_o row %0d got 0x%h exp 0x%h",
                           exp_row_i, wb_dat_i, exp_dat_i);
               end
            end
            wait_q = 1'b0;
         end else if (wait_q) begin
            err_cnt_o++;
            t_err++;
            $display("no ack came for the bus request to row %0d", exp_row_i);
            wait_q = 1'b0;
         end else if (wb_cyc_i && wb_stb_i) begin
            wait_q = 1'b1;
         end
         if (test_end_i) begin
            $display("test %0d: %0d reads checked, %0d errors, %s", test_id_i, t_chk, t_err,
                     (t_err == 0) ? "ok" : "FAILED");
            n_test++;
            t_chk = 0;
            t_err = 0;
         end
         if (all_done_i) begin
            $display("summary: %0d tests, %0d reads checked, %0d errors",
                     n_test, chk_cnt_o, err_cnt_o);
         end
      end
   end

endmodule

// ==== verification/tb_mosaic.sv ====
`timescale 1ns/10ps

module tb_mosaic;

   localparam int NF        = 6; // Frames in the stimulus table.
   localparam int NB        = mosaic_geom_pkg::HBLKS * mosaic_geom_pkg::VBLKS;
   localparam int GAP       = 12; // Idle cycles after every line and before vs.
   localparam int FRAME_CYC = mosaic_geom_pkg::FRAME_H * (mosaic_geom_pkg::FRAME_W + GAP)
                            + 8 * (mosaic_geom_pkg::VBLKS + 4);
   localparam int WD_NS     = (NF + 2) * FRAME_CYC * 40 * 2;

   logic                                clk = 1'b0;
   logic                                rst_n;
   logic                                vs;
   logic                                de;
   logic [23:0]                         wd;
   logic                                wb_cyc;
   logic                                wb_stb;
   logic                                wb_we;
   logic [mosaic_bus_pkg::WB_ADR_W-1:0] wb_adr;
   logic [mosaic_bus_pkg::WB_DAT_W-1:0] wb_dat;
   logic                                wb_ack;

   logic                                cmp;
   int                                  exp_row;
   logic [mosaic_bus_pkg::WB_DAT_W-1:0] exp_dat;
   logic [7:0]                          test_id;
   logic                                test_end;
   logic                                all_done;
   int                                  err_cnt;
   int                                  chk_cnt;
   int                                  n_reads;

   // Stimulus table, one entry per block, plus the expected bitmap rows.
   logic [15:0]                       lfsr;
   logic                              fixed    [NF][NB];
   logic                              chk_mode [NF][NB];
   logic [23:0]                       col_a    [NF][NB];
   logic [23:0]                       col_b    [NF][NB];
   logic [mosaic_geom_pkg::HBLKS-1:0] exp_rows [NF][mosaic_geom_pkg::VBLKS];

   always #20 clk = ~clk;

   mosaic_top i_dut (
      .clk_i    (clk),
      .rst_n_i  (rst_n),
      .vs_i     (vs),
      .de_i     (de),
      .wd_i     (wd),
      .wb_cyc_i (wb_cyc),
      .wb_stb_i (wb_stb),
      .wb_we_i  (wb_we),
      .wb_adr_i (wb_adr),
      .wb_dat_o (wb_dat),
      .wb_ack_o (wb_ack)
   );

   mosaic_checker i_chk (
      .clk_i      (clk),
      .rst_n_i    (rst_n),
      .wb_cyc_i   (wb_cyc),
      .wb_stb_i   (wb_stb),
      .wb_ack_i   (wb_ack),
      .wb_dat_i   (wb_dat),
      .cmp_i      (cmp),
      .exp_row_i  (exp_row),
      .exp_dat_i  (exp_dat),
      .test_id_i  (test_id),
      .test_end_i (test_end),
      .all_done_i (all_done),
      .err_cnt_o  (err_cnt),
      .chk_cnt_o  (chk_cnt)
   );

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   task automatic draw_colour(output logic [23:0] c);
      c = '0;
      for (int i = 0; i < 24; i++) begin
         c    = {c[22:0], lfsr[0]}; // One LFSR step per bit.
         lfsr = lfsr_next(lfsr);
      end
   endtask

   function automatic logic [23:0] pixel_colour(input int f, input int x, input int y);
      int b;
      b = (y / mosaic_geom_pkg::BLK_H) * mosaic_geom_pkg::HBLKS + x / mosaic_geom_pkg::BLK_W;
      if (chk_mode[f][b] && ((x + y) % 2 == 1)) return col_b[f][b];
      return col_a[f][b];
   endfunction

   // Block bit from the weighted sum over every pixel of the block.
   function automatic logic block_bit(input int f, input int b);
      longint      sum;
      logic [23:0] c;
      int          x0;
      int          y0;
      sum = 0;
      x0  = (b % mosaic_geom_pkg::HBLKS) * mosaic_geom_pkg::BLK_W;
      y0  = (b / mosaic_geom_pkg::HBLKS) * mosaic_geom_pkg::BLK_H;
      for (int y = 0; y < mosaic_geom_pkg::BLK_H; y++) begin
         for (int x = 0; x < mosaic_geom_pkg::BLK_W; x++) begin
            c   = pixel_colour(f, x0 + x, y0 + y);
            sum = sum + longint'(mosaic_geom_pkg::W_R) * longint'(c[23:16])
                      + longint'(mosaic_geom_pkg::W_G) * longint'(c[15:8])
                      + longint'(mosaic_geom_pkg::W_B) * longint'(c[7:0]);
         end
      end
      return sum >= longint'(mosaic_geom_pkg::LUMA_THRES);
   endfunction

   function automatic logic [mosaic_bus_pkg::WB_DAT_W-1:0] expected_word(input int f,
                                                                          input int r);
      logic [mosaic_bus_pkg::WB_DAT_W-1:0] e;
      e = '0;
      if (f >= 0) e[mosaic_geom_pkg::HBLKS-1:0] = exp_rows[f][r];
      return e;
   endfunction

   task automatic put(input int f, input int b, input logic chk, input logic [23:0] a,
                      input logic [23:0] c);
      fixed[f][b]    = 1'b1;
      chk_mode[f][b] = chk;
      col_a[f][b]    = a;
      col_b[f][b]    = c;
   endtask

   task automatic build_table();
      logic [23:0] c;
      for (int f = 0; f < NF; f++) begin
         for (int b = 0; b < NB; b++) begin
            fixed[f][b]    = 1'b0;
            chk_mode[f][b] = 1'b0;
            col_b[f][b]    = '0;
         end
      end
      put(0, 0, 1'b0, 24'h7F7F7F, 24'h0); // Threshold edge.
      put(0, 1, 1'b0, 24'h808080, 24'h0);
      put(0, 2, 1'b0, 24'h7F7F7F, 24'h0);
      put(0, 3, 1'b0, 24'h808080, 24'h0);
      put(1, 0, 1'b0, 24'h00FF00, 24'h0); // Weighting.
      put(1, 1, 1'b0, 24'hFF0000, 24'h0);
      put(1, 2, 1'b0, 24'h0000FF, 24'h0);
      put(2, 0, 1'b1, 24'hFFFFFF, 24'h000000); // Mean 127.5 stays below.
      put(2, 1, 1'b1, 24'hFFFFFF, 24'h020202);
      put(2, 5, 1'b1, 24'h000000, 24'hFFFFFF);
      put(2, 6, 1'b1, 24'h020202, 24'hFFFFFF);
      for (int f = 0; f < NF; f++) begin
         for (int b = 0; b < NB; b++) begin
            if (!fixed[f][b]) begin
               draw_colour(c);
               col_a[f][b] = c;
            end
         end
         for (int r = 0; r < mosaic_geom_pkg::VBLKS; r++) begin
            for (int h = 0; h < mosaic_geom_pkg::HBLKS; h++) begin
               exp_rows[f][r][h] = block_bit(f, r * mosaic_geom_pkg::HBLKS + h);
            end
         end
      end
   endtask

   task automatic step();
      @(posedge clk);
      #2;
   endtask

   task automatic bus_cycle(input logic we, input logic [mosaic_bus_pkg::WB_ADR_W-1:0] adr,
                            input logic [mosaic_bus_pkg::WB_DAT_W-1:0] exp_val, input int row);
      int tries;
      cmp     = ~we;
      exp_row = row;
      exp_dat = exp_val;
      wb_we   = we;
      wb_adr  = adr;
      wb_cyc  = 1'b1;
      wb_stb  = 1'b1;
      if (!we) n_reads++;
      tries = 0;
      do begin
         step();
         tries++;
      end while (!wb_ack && tries < 4);
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
      step(); // The checker samples the ack on this edge.
   endtask

   task automatic read_rows(input int f);
      for (int r = 0; r < mosaic_geom_pkg::VBLKS; r++) begin
         bus_cycle(1'b0, mosaic_bus_pkg::ROW_BASE + mosaic_bus_pkg::WB_ADR_W'(r),
                   expected_word(f, r), r);
      end
   endtask

   task automatic frame_start();
      vs = 1'b1;
      step();
      vs = 1'b0;
      step();
      step();
   endtask

   // Mid-frame read of row 0 must still show the previous frame.
   task automatic drive_frame(input int f);
      for (int y = 0; y < mosaic_geom_pkg::FRAME_H; y++) begin
         for (int x = 0; x < mosaic_geom_pkg::FRAME_W; x++) begin
            de = 1'b1;
            wd = pixel_colour(f, x, y);
            step();
         end
         de = 1'b0;
         wd = '0;
         if (y == mosaic_geom_pkg::BLK_H) bus_cycle(1'b0, mosaic_bus_pkg::ROW_BASE,
                                                    expected_word(f - 1, 0), 0);
         repeat (GAP) step();
      end
   endtask

   task automatic end_test(input int id);
      test_id  = 8'(id);
      test_end = 1'b1;
      step();
      test_end = 1'b0;
   endtask

   initial begin
      rst_n    = 1'b0;
      vs       = 1'b0;
      de       = 1'b0;
      wd       = '0;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = '0;
      cmp      = 1'b0;
      exp_row  = 0;
      exp_dat  = '0;
      test_id  = '0;
      test_end = 1'b0;
      all_done = 1'b0;
      n_reads  = 0;
      lfsr     = 16'd60;
      build_table();
      repeat (10) @(posedge clk);
      #2;
      rst_n = 1'b1;
      step();
      read_rows(-1);
      for (int f = 0; f < NF; f++) begin
         frame_start();
         read_rows(f - 1);
         drive_frame(f);
         end_test(f);
      end
      frame_start();
      read_rows(NF - 1);
      bus_cycle(1'b1, mosaic_bus_pkg::ROW_BASE, '0, 0); // Writes are ignored.
      bus_cycle(1'b0, mosaic_bus_pkg::ROW_BASE, expected_word(NF - 1, 0), 0);
      bus_cycle(1'b0, mosaic_bus_pkg::ROW_BASE + mosaic_bus_pkg::ROW_CNT, '0,
                mosaic_geom_pkg::VBLKS);
      bus_cycle(1'b0, mosaic_bus_pkg::ROW_BASE - 1'b1, '0, -1);
      end_test(NF);
      all_done = 1'b1;
      step();
      all_done = 1'b0;
      step();
      if (chk_cnt != n_reads) begin
         $display("only %0d of %0d reads were acknowledged and checked", chk_cnt, n_reads);
      end
      if (err_cnt == 0 && chk_cnt == n_reads) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

   initial begin
      #(WD_NS);
      $display("watchdog expired, the run did not finish within %0d ns", WD_NS);
      $display("Test failures found");
      $finish;
   end

endmodule

// ==== tb.f ====
hw/mosaic_geom_pkg.sv
hw/mosaic_bus_pkg.sv
hw/blk_timing.sv
hw/luma_accum.sv
hw/blk_bitmap.sv
hw/mosaic_top.sv
verification/mosaic_checker.sv
verification/tb_mosaic.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the mosaic testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_mosaic \
   || { echo "build failed"; exit 1; }

out=$(./obj_dir/Vtb_mosaic)
echo "$out"
echo "$out" | grep -qx "All tests passed!" && exit 0 || exit 1
